/* src/beam_pkg.sv */
// beamforming combiner definitions
`default_nettype none

package beam_pkg;

    // bits in one signed sample of a channel word
    localparam int sample_width = 16;

    // bits in the real or the imaginary part of a weight
    localparam int weight_width = 8;

    // samples carried side by side in one beat
    localparam int lanes = 8;

    // channels that are weighted and summed into the output stream
    localparam int channels = 4;

    // weights are fixed point with this many fraction bits, so every
    // product is shifted right by the same amount before it is kept
    localparam int frac_bits = 7;

    // one signed sample as it sits in a channel word
    typedef logic signed [sample_width-1:0] sample_t;

    // one signed weight part, real or imaginary
    typedef logic signed [weight_width-1:0] weight_t;

    // one beat of samples, lane 0 in the low bits
    typedef logic [lanes*sample_width-1:0] word_t;

    // a sample times a weight part at full precision, before the shift
    typedef logic signed [sample_width+weight_width-1:0] product_t;

endpackage

`default_nettype wire

/* src/chan_if.sv */
// channel pipeline item
`timescale 1ns/10ps
`default_nettype none

// one channel's item as it moves from one pipeline stage to the next
// valid only marks a slot that holds data, the stall comes from outside
interface chan_if;

    logic valid;
    logic last;
    beam_pkg::word_t re;
    beam_pkg::word_t im;

    // the stage that owns the registers
    modport source (output valid, output last, output re, output im);

    // the stage that consumes them
    modport sink (input valid, input last, input re, input im);

endinterface

`default_nettype wire

/* src/beam_capture.sv */
// input capture stage
`timescale 1ns/10ps
`default_nettype none

// stage 1 of the combiner
// a beat is only taken when all four channels offer one, since the sum
// further down needs every channel of the same beat at once
module beam_capture (
    input  logic clock,
    input  logic resetn,
    input  logic advance,
    input  logic [beam_pkg::channels-1:0] ch_valid,
    input  logic ch0_last,
    input  beam_pkg::word_t ch0_re,
    input  beam_pkg::word_t ch1_re,
    input  beam_pkg::word_t ch2_re,
    input  beam_pkg::word_t ch3_re,
    input  beam_pkg::word_t ch0_im,
    input  beam_pkg::word_t ch1_im,
    input  beam_pkg::word_t ch2_im,
    input  beam_pkg::word_t ch3_im,
    input  beam_pkg::weight_t [beam_pkg::channels-1:0] w_re,
    input  beam_pkg::weight_t [beam_pkg::channels-1:0] w_im,
    output logic ready,
    chan_if.source ch_out0,
    chan_if.source ch_out1,
    chan_if.source ch_out2,
    chan_if.source ch_out3,
    output beam_pkg::weight_t [beam_pkg::channels-1:0] wr_q,
    output beam_pkg::weight_t [beam_pkg::channels-1:0] wi_q
);

    logic accept;
    logic valid_q;
    logic last_q;
    beam_pkg::word_t re_q [beam_pkg::channels];
    beam_pkg::word_t im_q [beam_pkg::channels];

    // the whole pipeline moves with the downstream ready, so the input
    // side can only take a beat when the output side lets things move
    assign ready = advance && resetn;

    // all channels must be valid in the same cycle
    assign accept = ready && (&ch_valid);

    // an empty slot enters the pipeline on every step without a beat
    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= accept;
        end
    end

    // the weights are captured together with the beat, which keeps a
    // weight change from reaching a beat that was taken before it
    always_ff @(posedge clock) begin
        if (accept) begin
            last_q <= ch0_last;
            re_q[0] <= ch0_re;
            re_q[1] <= ch1_re;
            re_q[2] <= ch2_re;
            re_q[3] <= ch3_re;
            im_q[0] <= ch0_im;
            im_q[1] <= ch1_im;
            im_q[2] <= ch2_im;
            im_q[3] <= ch3_im;
            wr_q <= w_re;
            wi_q <= w_im;
        end
    end

    // every channel item shares one valid and channel 0's last flag
    assign ch_out0.valid = valid_q;
    assign ch_out0.last = last_q;
    assign ch_out0.re = re_q[0];
    assign ch_out0.im = im_q[0];

    assign ch_out1.valid = valid_q;
    assign ch_out1.last = last_q;
    assign ch_out1.re = re_q[1];
    assign ch_out1.im = im_q[1];

    assign ch_out2.valid = valid_q;
    assign ch_out2.last = last_q;
    assign ch_out2.re = re_q[2];
    assign ch_out2.im = im_q[2];

    assign ch_out3.valid = valid_q;
    assign ch_out3.last = last_q;
    assign ch_out3.re = re_q[3];
    assign ch_out3.im = im_q[3];

endmodule

`default_nettype wire

/* src/complex_weight.sv */
// complex weight multiply
`timescale 1ns/10ps
`default_nettype none

// stages 2 and 3, one channel times its complex weight, lane by lane
module complex_weight (
    input  logic clock,
    input  logic resetn,
    input  logic advance,
    input  beam_pkg::weight_t w_re,
    input  beam_pkg::weight_t w_im,
    chan_if.sink din,
    chan_if.source dout
);

    beam_pkg::sample_t sr [beam_pkg::lanes];
    beam_pkg::sample_t si [beam_pkg::lanes];
    beam_pkg::product_t rr [beam_pkg::lanes];
    beam_pkg::product_t ii [beam_pkg::lanes];
    beam_pkg::product_t ri [beam_pkg::lanes];
    beam_pkg::product_t ir [beam_pkg::lanes];
    logic valid_p;
    logic last_p;
    logic valid_q;
    logic last_q;
    beam_pkg::word_t re_n;
    beam_pkg::word_t im_n;
    beam_pkg::word_t re_q;
    beam_pkg::word_t im_q;

    // one extra bit holds the difference of two extreme products, then
    // the weight scaling drops the fraction and the low bits are kept
    function automatic beam_pkg::sample_t combine(input beam_pkg::product_t a,
                                                  input beam_pkg::product_t b,
                                                  input logic subtract);
        logic signed [$bits(beam_pkg::product_t):0] wa;
        logic signed [$bits(beam_pkg::product_t):0] wb;
        logic signed [$bits(beam_pkg::product_t):0] acc;
        wa = a;
        wb = b;
        if (subtract) begin
            acc = wa - wb;
        end else begin
            acc = wa + wb;
        end
        acc = acc >>> beam_pkg::frac_bits;
        return acc[beam_pkg::sample_width-1:0];
    endfunction

    // split the words into signed samples, lane 0 from the low bits
    always_comb begin
        for (int i = 0; i < beam_pkg::lanes; i++) begin
            sr[i] = din.re[i*beam_pkg::sample_width +: beam_pkg::sample_width];
            si[i] = din.im[i*beam_pkg::sample_width +: beam_pkg::sample_width];
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            valid_p <= 1'b0;
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_p <= din.valid;
            valid_q <= valid_p;
        end
    end

    // stage 2 keeps all four partial products at full width
    always_ff @(posedge clock) begin
        if (advance) begin
            last_p <= din.last;
            for (int i = 0; i < beam_pkg::lanes; i++) begin
                rr[i] <= sr[i] * w_re;
                ii[i] <= si[i] * w_im;
                ri[i] <= sr[i] * w_im;
                ir[i] <= si[i] * w_re;
            end
        end
    end

    // real part is rr - ii and imaginary part is ri + ir
    always_comb begin
        for (int i = 0; i < beam_pkg::lanes; i++) begin
            re_n[i*beam_pkg::sample_width +: beam_pkg::sample_width] = combine(rr[i], ii[i], 1'b1);
            im_n[i*beam_pkg::sample_width +: beam_pkg::sample_width] = combine(ri[i], ir[i], 1'b0);
        end
    end

    // stage 3 register
    always_ff @(posedge clock) begin
        if (advance) begin
            last_q <= last_p;
            re_q <= re_n;
            im_q <= im_n;
        end
    end

    assign dout.valid = valid_q;
    assign dout.last = last_q;
    assign dout.re = re_q;
    assign dout.im = im_q;

endmodule

`default_nettype wire

/* src/beam_sum.sv */
// four channel adder
`timescale 1ns/10ps
`default_nettype none

// stage 4, adds the weighted channels lane by lane into the output beat
module beam_sum (
    input  logic clock,
    input  logic resetn,
    input  logic advance,
    chan_if.sink c0,
    chan_if.sink c1,
    chan_if.sink c2,
    chan_if.sink c3,
    output logic m_valid,
    output logic m_last,
    output beam_pkg::word_t m_re,
    output beam_pkg::word_t m_im
);

    beam_pkg::word_t sum_re;
    beam_pkg::word_t sum_im;

    // two guard bits cover four terms, the result wraps to 16 bits
    function automatic beam_pkg::sample_t add4(input beam_pkg::sample_t a,
                                               input beam_pkg::sample_t b,
                                               input beam_pkg::sample_t c,
                                               input beam_pkg::sample_t d);
        logic signed [beam_pkg::sample_width+1:0] acc;
        acc = a;
        acc = acc + b;
        acc = acc + c;
        acc = acc + d;
        return acc[beam_pkg::sample_width-1:0];
    endfunction

    always_comb begin
        for (int i = 0; i < beam_pkg::lanes; i++) begin
            sum_re[i*beam_pkg::sample_width +: beam_pkg::sample_width] = add4(
                c0.re[i*beam_pkg::sample_width +: beam_pkg::sample_width],
                c1.re[i*beam_pkg::sample_width +: beam_pkg::sample_width],
                c2.re[i*beam_pkg::sample_width +: beam_pkg::sample_width],
                c3.re[i*beam_pkg::sample_width +: beam_pkg::sample_width]);
            sum_im[i*beam_pkg::sample_width +: beam_pkg::sample_width] = add4(
                c0.im[i*beam_pkg::sample_width +: beam_pkg::sample_width],
                c1.im[i*beam_pkg::sample_width +: beam_pkg::sample_width],
                c2.im[i*beam_pkg::sample_width +: beam_pkg::sample_width],
                c3.im[i*beam_pkg::sample_width +: beam_pkg::sample_width]);
        end
    end

    // channel items move in lockstep, so channel 0 speaks for all four
    always_ff @(posedge clock) begin
        if (!resetn) begin
            m_valid <= 1'b0;
        end else if (advance) begin
            m_valid <= c0.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            m_last <= c0.last;
            m_re <= sum_re;
            m_im <= sum_im;
        end
    end

endmodule

`default_nettype wire

/* src/beam_combiner.sv */
// beamforming combiner top
`timescale 1ns/10ps
`default_nettype none

// four complex channels weighted and summed into one output stream
// the pipeline is four stages deep and stalls as a whole on m_tready
module beam_combiner (
    input  logic clock,
    input  logic resetn,
    input  logic ch0_tvalid,
    input  logic ch1_tvalid,
    input  logic ch2_tvalid,
    input  logic ch3_tvalid,
    input  logic ch0_tlast,
    input  beam_pkg::word_t ch0_re_tdata,
    input  beam_pkg::word_t ch1_re_tdata,
    input  beam_pkg::word_t ch2_re_tdata,
    input  beam_pkg::word_t ch3_re_tdata,
    input  beam_pkg::word_t ch0_im_tdata,
    input  beam_pkg::word_t ch1_im_tdata,
    input  beam_pkg::word_t ch2_im_tdata,
    input  beam_pkg::word_t ch3_im_tdata,
    input  beam_pkg::weight_t ch0_w_re,
    input  beam_pkg::weight_t ch1_w_re,
    input  beam_pkg::weight_t ch2_w_re,
    input  beam_pkg::weight_t ch3_w_re,
    input  beam_pkg::weight_t ch0_w_im,
    input  beam_pkg::weight_t ch1_w_im,
    input  beam_pkg::weight_t ch2_w_im,
    input  beam_pkg::weight_t ch3_w_im,
    output logic s_tready,
    output logic m_tvalid,
    output logic m_tlast,
    output beam_pkg::word_t m_re_tdata,
    output beam_pkg::word_t m_im_tdata,
    input  logic m_tready
);

    // weights as captured with the beat in stage 1
    beam_pkg::weight_t [beam_pkg::channels-1:0] wr_q;
    beam_pkg::weight_t [beam_pkg::channels-1:0] wi_q;

    // capture to multiply, one per channel
    chan_if cap0 ();
    chan_if cap1 ();
    chan_if cap2 ();
    chan_if cap3 ();

    // multiply to adder, one per channel
    chan_if wt0 ();
    chan_if wt1 ();
    chan_if wt2 ();
    chan_if wt3 ();

    beam_capture u_capture (
        .clock    (clock),
        .resetn   (resetn),
        .advance  (m_tready),
        .ch_valid ({ch3_tvalid, ch2_tvalid, ch1_tvalid, ch0_tvalid}),
        .ch0_last (ch0_tlast),
        .ch0_re   (ch0_re_tdata),
        .ch1_re   (ch1_re_tdata),
        .ch2_re   (ch2_re_tdata),
        .ch3_re   (ch3_re_tdata),
        .ch0_im   (ch0_im_tdata),
        .ch1_im   (ch1_im_tdata),
        .ch2_im   (ch2_im_tdata),
        .ch3_im   (ch3_im_tdata),
        .w_re     ({ch3_w_re, ch2_w_re, ch1_w_re, ch0_w_re}),
        .w_im     ({ch3_w_im, ch2_w_im, ch1_w_im, ch0_w_im}),
        .ready    (s_tready),
        .ch_out0  (cap0),
        .ch_out1  (cap1),
        .ch_out2  (cap2),
        .ch_out3  (cap3),
        .wr_q     (wr_q),
        .wi_q     (wi_q)
    );

    complex_weight u_weight0 (.clock(clock), .resetn(resetn), .advance(m_tready),
        .w_re(wr_q[0]), .w_im(wi_q[0]), .din(cap0), .dout(wt0));

    complex_weight u_weight1 (.clock(clock), .resetn(resetn), .advance(m_tready),
        .w_re(wr_q[1]), .w_im(wi_q[1]), .din(cap1), .dout(wt1));

    complex_weight u_weight2 (.clock(clock), .resetn(resetn), .advance(m_tready),
        .w_re(wr_q[2]), .w_im(wi_q[2]), .din(cap2), .dout(wt2));

    complex_weight u_weight3 (.clock(clock), .resetn(resetn), .advance(m_tready),
        .w_re(wr_q[3]), .w_im(wi_q[3]), .din(cap3), .dout(wt3));

    beam_sum u_sum (
        .clock   (clock),
        .resetn  (resetn),
        .advance (m_tready),
        .c0      (wt0),
        .c1      (wt1),
        .c2      (wt2),
        .c3      (wt3),
        .m_valid (m_tvalid),
        .m_last  (m_tlast),
        .m_re    (m_re_tdata),
        .m_im    (m_im_tdata)
    );

endmodule

`default_nettype wire

/* tests/tb_beam_combiner.sv */
// beamforming combiner testbench
`timescale 1ns/10ps
`default_nettype none

module tb_beam_combiner;

    // entries per case in the case file, see the comment at its top
    localparam int fields = 19;
    localparam int max_cases = 16;
    // rising edges from accept to the output beat with no stall
    localparam int pipe_depth = 4;

    logic clock;
    logic resetn;
    logic [3:0] ch_valid;
    logic ch0_tlast;
    beam_pkg::word_t ch_re [4];
    beam_pkg::word_t ch_im [4];
    beam_pkg::weight_t w_re [4];
    beam_pkg::weight_t w_im [4];
    logic s_tready;
    logic m_tvalid;
    logic m_tlast;
    beam_pkg::word_t m_re_tdata;
    beam_pkg::word_t m_im_tdata;
    logic m_tready;

    // entry 0 holds the case count, the cases follow it
    logic [127:0] case_mem [0:fields*max_cases];
    int num_cases;
    int timeout_limit;
    int cycles;
    int errors;
    int checks;
    int beats_in;
    int beats_out;
    logic stream_mode;
    logic stall_mode;
    logic [15:0] lfsr;

    // expected results in accept order
    beam_pkg::word_t exp_re_q [$];
    beam_pkg::word_t exp_im_q [$];
    logic exp_last_q [$];
    int accept_cycle_q [$];

    beam_combiner DUT (
        .clock        (clock),
        .resetn       (resetn),
        .ch0_tvalid   (ch_valid[0]),
        .ch1_tvalid   (ch_valid[1]),
        .ch2_tvalid   (ch_valid[2]),
        .ch3_tvalid   (ch_valid[3]),
        .ch0_tlast    (ch0_tlast),
        .ch0_re_tdata (ch_re[0]),
        .ch1_re_tdata (ch_re[1]),
        .ch2_re_tdata (ch_re[2]),
        .ch3_re_tdata (ch_re[3]),
        .ch0_im_tdata (ch_im[0]),
        .ch1_im_tdata (ch_im[1]),
        .ch2_im_tdata (ch_im[2]),
        .ch3_im_tdata (ch_im[3]),
        .ch0_w_re     (w_re[0]),
        .ch1_w_re     (w_re[1]),
        .ch2_w_re     (w_re[2]),
        .ch3_w_re     (w_re[3]),
        .ch0_w_im     (w_im[0]),
        .ch1_w_im     (w_im[1]),
        .ch2_w_im     (w_im[2]),
        .ch3_w_im     (w_im[3]),
        .s_tready     (s_tready),
        .m_tvalid     (m_tvalid),
        .m_tlast      (m_tlast),
        .m_re_tdata   (m_re_tdata),
        .m_im_tdata   (m_im_tdata),
        .m_tready     (m_tready)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    // the run is cut off once it outlives the worst case stall pattern
    always @(posedge clock) begin
        cycles++;
        if (cycles > timeout_limit) begin
            $display("timeout after %0d cycles, %0d beats still pending", cycles,
                     exp_re_q.size());
            $display("Test FAILED");
            $finish;
        end
    end

    // taps 16 14 13 11, shifted left with the feedback in bit 0
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one step of the register for every bit taken
    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[15]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_word(input string what, input beam_pkg::word_t got,
                              input beam_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_latency(input int got);
        checks++;
        if (got != pipe_depth) begin
            errors++;
            $display("ERR %0t: output came %0d edges after accept, expected %0d", $time,
                     got, pipe_depth);
        end
    endtask

    // random stalls on the output side, drawn just after each rising edge
    always @(posedge clock) begin
        int ready_bit;
        #1;
        if (stall_mode) begin
            draw_bits(1, ready_bit);
            m_tready = ready_bit[0];
        end
    end

    // outputs are looked at mid cycle, where a transfer at the next edge is known
    always @(negedge clock) begin
        if (resetn !== 1'b1) begin
            check_flag("m_tvalid in reset", m_tvalid, 1'b0);
            check_flag("s_tready in reset", s_tready, 1'b0);
        end else begin
            check_flag("s_tready", s_tready, m_tready);
            if (m_tvalid === 1'b1 && m_tready === 1'b1) begin
                if (exp_re_q.size() == 0) begin
                    errors++;
                    $display("an output beat came out with no accepted case to match it");
                end else begin
                    check_word("m_re_tdata", m_re_tdata, exp_re_q.pop_front());
                    check_word("m_im_tdata", m_im_tdata, exp_im_q.pop_front());
                    check_flag("m_tlast", m_tlast, exp_last_q.pop_front());
                    if (stream_mode) begin
                        check_latency(cycles - accept_cycle_q.pop_front());
                    end else begin
                        void'(accept_cycle_q.pop_front());
                    end
                    beats_out++;
                end
            end
        end
    end

    // drives one case until it is taken, then optionally idles the channels
    task automatic send_case(input int idx, input logic gaps);
        int b;
        int gap;
        logic accepted;
        b = 1 + idx * fields;
        for (int k = 0; k < 4; k++) begin
            w_re[k] = case_mem[b+k][7:0];
            w_im[k] = case_mem[b+4+k][7:0];
            ch_re[k] = case_mem[b+9+k];
            ch_im[k] = case_mem[b+13+k];
        end
        ch0_tlast = case_mem[b+8][0];
        ch_valid = 4'hf;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clock);
            // all channels valid and s_tready high means the next edge takes it
            if (s_tready === 1'b1) begin
                accepted = 1'b1;
                exp_re_q.push_back(case_mem[b+17]);
                exp_im_q.push_back(case_mem[b+18]);
                exp_last_q.push_back(case_mem[b+8][0]);
                accept_cycle_q.push_back(cycles);
                beats_in++;
            end
            @(posedge clock);
            #1;
        end
        if (gaps) begin
            ch_valid = 4'h0;
            @(negedge clock);
            draw_bits(2, gap);
            repeat (gap) @(negedge clock);
            @(posedge clock);
            #1;
        end
    endtask

    task automatic wait_drain();
        while (exp_re_q.size() != 0) @(negedge clock);
        repeat (2) @(negedge clock);
    endtask

    task automatic report_test(input string name, input int beats, input int errors_before);
        $display("%s: %0d beats, %0d errors", name, beats, errors - errors_before);
    endtask

    initial begin
        int errors_before;
        int beats_before;
        resetn = 1'b0;
        m_tready = 1'b1;
        ch_valid = 4'h0;
        ch0_tlast = 1'b0;
        for (int k = 0; k < 4; k++) begin
            ch_re[k] = '0;
            ch_im[k] = '0;
            w_re[k] = '0;
            w_im[k] = '0;
        end
        lfsr = 16'd60;
        cycles = 0;
        errors = 0;
        checks = 0;
        beats_in = 0;
        beats_out = 0;
        stream_mode = 1'b0;
        stall_mode = 1'b0;
        timeout_limit = 100;
        $readmemh("tests/beam_cases.txt", case_mem);
        num_cases = int'(case_mem[0]);
        // a broken case file runs no case and ends the run as a failure
        if (num_cases < 1 || num_cases > max_cases) begin
            errors++;
            $display("the case file holds no usable case count");
            num_cases = 0;
        end
        // each case runs once streaming and once with stalls
        timeout_limit = 2 * num_cases * 24 + 100;

        // m_tready stays high in reset so that s_tready shows the reset gating
        errors_before = errors;
        repeat (3) @(posedge clock);
        #1;
        resetn = 1'b1;
        report_test("reset", 0, errors_before);

        // empty slots only, the output must stay idle
        errors_before = errors;
        repeat (6) @(posedge clock);
        #1;
        report_test("idle", 0, errors_before);

        // back to back beats with no stall check the fixed latency
        errors_before = errors;
        beats_before = beats_out;
        stream_mode = 1'b1;
        for (int i = 0; i < num_cases; i++) begin
            send_case(i, 1'b0);
        end
        ch_valid = 4'h0;
        wait_drain();
        stream_mode = 1'b0;
        report_test("stream", beats_out - beats_before, errors_before);

        // gaps on the input and random stalls on the output
        errors_before = errors;
        beats_before = beats_out;
        stall_mode = 1'b1;
        @(posedge clock);
        #1;
        for (int i = 0; i < num_cases; i++) begin
            send_case(i, 1'b1);
        end
        wait_drain();
        stall_mode = 1'b0;
        report_test("stall", beats_out - beats_before, errors_before);

        $display("checks %0d, errors %0d, beats in %0d, beats out %0d", checks, errors,
                 beats_in, beats_out);
        if (errors == 0 && beats_in == 2 * num_cases && beats_out == beats_in) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/beam_cases.txt */
// case count first, then per case: w_re ch0..3, w_im ch0..3, last flag,
// re words ch0..3, im words ch0..3, expected m_re and m_im (lane 7 leftmost)
5
// unit weight on channel 0, a different sample in every lane
7f 0 0 0 0 0 0 0 0
08000700060005000400030002000100 0 0 0
F800F900FA00FB00FC00FD00FE00FF00 0 0 0
07F006F205F404F603F802FA01FC00FE F810F90EFA0CFB0AFC08FD06FE04FF02
// weight -1 on all channels, the lane sums wrap past 16 bits
80 80 80 80 0 0 0 0 0
E000E000E000E000E000E000E000E000 E000E000E000E000E000E000E000E000
E000E000E000E000E000E000E000E000 E000E000E000E000E000E000E000E000
10001000100010001000100010001000 10001000100010001000100010001000
10001000100010001000100010001000 10001000100010001000100010001000
80008000800080008000800080008000 C000C000C000C000C000C000C000C000
// mixed complex weights, channel 3 weighted by zero
40 00 80 00 C0 80 80 00 1
01000100010001000100010001000100 00100010001000100010001000100010
FFF0FFF0FFF0FFF0FFF0FFF0FFF0FFF0 7FFF7FFF7FFF7FFF7FFF7FFF7FFF7FFF
00800080008000800080008000800080 00200020002000200020002000200020
00080008000800080008000800080008 7FFF7FFF7FFF7FFF7FFF7FFF7FFF7FFF
00F800F800F800F800F800F800F800F8 FFB8FFB8FFB8FFB8FFB8FFB8FFB8FFB8
// half weight, the arithmetic shift rounds toward minus infinity
40 0 0 0 0 0 0 0 0
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0 0 0
00030003000300030003000300030003 0 0 0
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 00010001000100010001000100010001
// unit weight on channel 2 only
0 0 7f 0 0 0 0 0 1
0 0 08000700060005000400030002000100 0
0 0 F800F900FA00FB00FC00FD00FE00FF00 0
07F006F205F404F603F802FA01FC00FE F810F90EFA0CFB0AFC08FD06FE04FF02

/* sim.f */
src/beam_pkg.sv
src/chan_if.sv
src/beam_capture.sv
src/complex_weight.sv
src/beam_sum.sv
src/beam_combiner.sv
tests/tb_beam_combiner.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_beam_combiner \
    -o tb_beam_combiner
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_beam_combiner)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
